// ==== cpu_params.sv ====
package cpu_params;

    // Fetch geometry.
    localparam int unsigned IF_WIDTH    = 2;            // Instructions per fetch block.
    localparam int unsigned LINE_BITS   = 256;
    localparam int unsigned LINE_BYTES  = LINE_BITS / 8;

    // Default cache and queue sizes.
    localparam int unsigned ICACHE_SETS = 16;
    localparam int unsigned QUEUE_DEPTH = 8;

    localparam logic [31:0] RESET_PC    = 32'h1eceb000;

    typedef logic [31:0]          addr_t;               // Byte address.
    typedef logic [31:0]          inst_t;
    typedef logic [LINE_BITS-1:0] line_t;               // Word j sits at bits [32*j +: 32].

endpackage

// ==== icache.sv ====
`timescale 1ns/1ps

module icache
import cpu_params::*;
#(
    parameter int unsigned IF_WIDTH    = cpu_params::IF_WIDTH,
    parameter int unsigned ICACHE_SETS = cpu_params::ICACHE_SETS
)(
    input  logic                    clk,
    input  logic                    prev_rst,

    input  logic                    icache_read,
    input  addr_t                   icache_addr,
    output logic                    icache_resp,
    output inst_t [IF_WIDTH-1:0]    icache_rdata,

    output logic                    mem_read,
    output addr_t                   mem_addr,
    input  line_t                   mem_rdata,
    input  logic                    mem_resp
);

    localparam int unsigned OFF_BITS  = $clog2(LINE_BYTES);
    localparam int unsigned IDX_BITS  = $clog2(ICACHE_SETS);
    localparam int unsigned TAG_BITS  = 32 - OFF_BITS - IDX_BITS;
    localparam int unsigned BLK_BYTES = IF_WIDTH * 4;
    localparam int unsigned BLK_BITS  = IF_WIDTH * 32;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [IDX_BITS-1:0] idx_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        RESPOND
    } state_t;

    state_t                 state;

    tag_t                   tag_arr  [ICACHE_SETS];
    line_t                  data_arr [ICACHE_SETS];
    logic [ICACHE_SETS-1:0] valid_arr;

    addr_t                  req_addr;
    idx_t                   req_idx;
    tag_t                   req_tag;
    logic [OFF_BITS-1:0]    req_off;
    line_t                  line;
    logic                   hit;

    assign req_off = req_addr[OFF_BITS-1:0];
    assign req_idx = req_addr[OFF_BITS +: IDX_BITS];
    assign req_tag = req_addr[31 -: TAG_BITS];

    assign line = data_arr[req_idx];
    assign hit  = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);

    // Hit answers in LOOKUP, a fill answers one cycle after mem_resp.
    assign icache_resp  = ((state == LOOKUP) && hit) || (state == RESPOND);
    assign icache_rdata = line[(req_off / BLK_BYTES) * BLK_BITS +: BLK_BITS];

    assign mem_read = (state == FILL);                  // Held until mem_resp.
    assign mem_addr = {req_addr[31:OFF_BITS], {OFF_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            state     <= IDLE;
            valid_arr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (icache_read) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state <= hit ? IDLE : FILL;
                end
                FILL: begin
                    if (mem_resp) begin
                        state              <= RESPOND;
                        valid_arr[req_idx] <= 1'b1;
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && icache_read) begin
            req_addr <= icache_addr;
        end
        if ((state == FILL) && mem_resp) begin
            tag_arr[req_idx]  <= req_tag;
            data_arr[req_idx] <= mem_rdata;             // Whole line at once.
        end
    end

endmodule

// ==== if1_stage.sv ====
`timescale 1ns/1ps

module if1_stage
import cpu_params::*;
#(
    parameter int unsigned IF_WIDTH = cpu_params::IF_WIDTH
)(
    input  logic                    clk,
    input  logic                    prev_rst,

    input  logic                    flush,
    input  addr_t                   pc_next,
    output addr_t                   pc,

    output logic                    nxt_valid,
    input  logic                    nxt_ready,
    output inst_t [IF_WIDTH-1:0]    insts,

    output logic                    icache_read,
    output addr_t                   icache_addr,
    input  logic                    icache_resp,
    input  inst_t [IF_WIDTH-1:0]    icache_rdata
);

    logic   restart;                // pc itself has not been fetched yet.
    logic   pending;                // One read outstanding.
    logic   stale;                  // Outstanding read predates a flush.
    logic   issue;
    addr_t  issue_pc;

    // A read goes out only when the output register is free or drains now.
    assign issue    = !pending && !flush && (!nxt_valid || nxt_ready);
    assign issue_pc = restart ? pc : pc_next;

    // pc is updated together with the strobe, so it is the address of the read.
    assign icache_addr = pc;

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            pc          <= pc_next;                     // Reset vector.
            restart     <= 1'b1;
            pending     <= 1'b0;
            stale       <= 1'b0;
            nxt_valid   <= 1'b0;
            icache_read <= 1'b0;
        end else begin
            icache_read <= issue;

            if (nxt_valid && nxt_ready) begin
                nxt_valid <= 1'b0;
            end

            if (icache_resp) begin
                pending <= 1'b0;
                stale   <= 1'b0;
                if (!stale && !flush) begin
                    nxt_valid <= 1'b1;
                end
            end

            if (flush) begin
                pc        <= pc_next;                   // Redirect target.
                restart   <= 1'b1;
                nxt_valid <= 1'b0;
                if (pending && !icache_resp) begin
                    stale <= 1'b1;                      // Drop it when it returns.
                end
            end else if (issue) begin
                pc      <= issue_pc;
                restart <= 1'b0;
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (icache_resp && !stale) begin
            insts <= icache_rdata;
        end
    end

endmodule

// ==== frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top
import cpu_params::*;
#(
    parameter int unsigned IF_WIDTH = cpu_params::IF_WIDTH
)(
    input  logic                    clk,
    input  logic                    prev_rst,

    input  logic                    backend_flush,
    input  addr_t                   backend_redirect_pc,

    output logic                    enq_valid,
    input  logic                    enq_ready,
    output inst_t [IF_WIDTH-1:0]    enq_data,
    output addr_t                   enq_pc,

    output logic                    icache_read,
    output addr_t                   icache_addr,
    input  logic                    icache_resp,
    input  inst_t [IF_WIDTH-1:0]    icache_rdata
);

    localparam int unsigned IF_BLK_SIZE = IF_WIDTH * 4;
    localparam addr_t       BLK_MASK    = ~addr_t'(IF_BLK_SIZE - 1);

    addr_t  pc_next;
    addr_t  pc;

    always_comb begin
        if (prev_rst) begin
            pc_next = RESET_PC;
        end else if (backend_flush) begin
            pc_next = backend_redirect_pc;
        end else begin
            pc_next = (pc + addr_t'(IF_BLK_SIZE)) & BLK_MASK;   // Next aligned block.
        end
    end

    if1_stage #(
        .IF_WIDTH       (IF_WIDTH)
    ) i_if1_stage (
        .clk            (clk),
        .prev_rst       (prev_rst),
        .flush          (backend_flush),
        .pc_next        (pc_next),
        .pc             (pc),
        .nxt_valid      (enq_valid),
        .nxt_ready      (enq_ready),
        .insts          (enq_data),
        .icache_read    (icache_read),
        .icache_addr    (icache_addr),
        .icache_resp    (icache_resp),
        .icache_rdata   (icache_rdata)
    );

    assign enq_pc = pc;                                 // PC of the registered block.

endmodule

// ==== instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue
import cpu_params::*;
#(
    parameter int unsigned IF_WIDTH    = cpu_params::IF_WIDTH,
    parameter int unsigned QUEUE_DEPTH = cpu_params::QUEUE_DEPTH
)(
    input  logic                    clk,
    input  logic                    prev_rst,
    input  logic                    flush,

    input  logic                    enq_valid,
    output logic                    enq_ready,
    input  inst_t [IF_WIDTH-1:0]    enq_data,
    input  addr_t                   enq_pc,

    output logic                    deq_valid,
    input  logic                    deq_ready,
    output inst_t [IF_WIDTH-1:0]    deq_data,
    output addr_t                   deq_pc
);

    localparam int unsigned PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    inst_t [IF_WIDTH-1:0]   data_mem [QUEUE_DEPTH];
    addr_t                  pc_mem   [QUEUE_DEPTH];

    ptr_t   rd_ptr;
    ptr_t   wr_ptr;
    cnt_t   count;
    logic   do_enq;
    logic   do_deq;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign enq_ready = (count != cnt_t'(QUEUE_DEPTH));
    assign deq_valid = (count != '0);
    assign do_enq    = enq_valid && enq_ready;
    assign do_deq    = deq_valid && deq_ready;

    assign deq_data  = data_mem[rd_ptr];
    assign deq_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (prev_rst || flush) begin
            rd_ptr <= '0;                               // Flush drops every entry.
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (!do_enq && do_deq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            data_mem[wr_ptr] <= enq_data;
            pc_mem[wr_ptr]   <= enq_pc;
        end
    end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
import cpu_params::*;
#(
    parameter int unsigned IF_WIDTH    = cpu_params::IF_WIDTH,
    parameter int unsigned ICACHE_SETS = cpu_params::ICACHE_SETS,
    parameter int unsigned QUEUE_DEPTH = cpu_params::QUEUE_DEPTH
)(
    input  logic                    clk,
    input  logic                    prev_rst,

    input  logic                    backend_flush,
    input  addr_t                   backend_redirect_pc,

    output logic                    instr_valid,
    input  logic                    instr_ready,
    output inst_t [IF_WIDTH-1:0]    instr_data,
    output addr_t                   instr_pc,

    output logic                    mem_read,
    output addr_t                   mem_addr,
    input  line_t                   mem_rdata,
    input  logic                    mem_resp
);

    logic                   enq_valid;
    logic                   enq_ready;
    inst_t [IF_WIDTH-1:0]   enq_data;
    addr_t                  enq_pc;

    logic                   icache_read;
    addr_t                  icache_addr;
    logic                   icache_resp;
    inst_t [IF_WIDTH-1:0]   icache_rdata;

    frontend_top #(
        .IF_WIDTH               (IF_WIDTH)
    ) i_frontend_top (
        .clk                    (clk),
        .prev_rst               (prev_rst),
        .backend_flush          (backend_flush),
        .backend_redirect_pc    (backend_redirect_pc),
        .enq_valid              (enq_valid),
        .enq_ready              (enq_ready),
        .enq_data               (enq_data),
        .enq_pc                 (enq_pc),
        .icache_read            (icache_read),
        .icache_addr            (icache_addr),
        .icache_resp            (icache_resp),
        .icache_rdata           (icache_rdata)
    );

    icache #(
        .IF_WIDTH               (IF_WIDTH),
        .ICACHE_SETS            (ICACHE_SETS)
    ) i_icache (
        .clk                    (clk),
        .prev_rst               (prev_rst),
        .icache_read            (icache_read),
        .icache_addr            (icache_addr),
        .icache_resp            (icache_resp),
        .icache_rdata           (icache_rdata),
        .mem_read               (mem_read),
        .mem_addr               (mem_addr),
        .mem_rdata              (mem_rdata),
        .mem_resp               (mem_resp)
    );

    instr_queue #(
        .IF_WIDTH               (IF_WIDTH),
        .QUEUE_DEPTH            (QUEUE_DEPTH)
    ) i_instr_queue (
        .clk                    (clk),
        .prev_rst               (prev_rst),
        .flush                  (backend_flush),
        .enq_valid              (enq_valid),
        .enq_ready              (enq_ready),
        .enq_data               (enq_data),
        .enq_pc                 (enq_pc),
        .deq_valid              (instr_valid),
        .deq_ready              (instr_ready),
        .deq_data               (instr_data),
        .deq_pc                 (instr_pc)
    );

endmodule

// ==== tb_cacheline_mem.sv ====
`timescale 1ns/1ps

module tb_cacheline_mem
import cpu_params::*;
(
    input  logic    clk,
    input  logic    prev_rst,
    input  logic    mem_read,
    input  addr_t   mem_addr,
    output line_t   mem_rdata,
    output logic    mem_resp,
    output int      read_count
);

    integer seed;
    logic   busy;
    int     delay;

    // Word at byte address a holds a ^ 32'h5a5a_0000.
    function automatic line_t line_data(input addr_t addr);
        line_t  data;
        addr_t  base;
        base = addr & ~addr_t'(LINE_BYTES - 1);
        for (int j = 0; j < LINE_BITS / 32; j++) begin
            data[32*j +: 32] = (base + addr_t'(4 * j)) ^ 32'h5a5a_0000;
        end
        return data;
    endfunction

    initial begin
        seed       = 32'hff0f_16d1;
        busy       = 1'b0;
        delay      = 0;
        mem_resp   = 1'b0;
        mem_rdata  = '0;
        read_count = 0;
    end

    always @(posedge clk) begin
        if (prev_rst) begin
            busy     <= 1'b0;
            mem_resp <= 1'b0;
        end else begin
            mem_resp <= 1'b0;
            if (busy) begin
                if (delay == 0) begin
                    busy      <= 1'b0;
                    mem_resp  <= 1'b1;                  // One-cycle pulse.
                    mem_rdata <= line_data(mem_addr);
                end else begin
                    delay <= delay - 1;
                end
            end else if (mem_read && !mem_resp) begin
                busy       <= 1'b1;
                delay      <= int'($unsigned($random(seed)) % 6);   // Answer in 1 to 6 cycles.
                read_count <= read_count + 1;
            end
        end
    end

endmodule

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top
import cpu_params::*;
();

    localparam int unsigned BLK_BYTES = IF_WIDTH * 4;
    localparam int          TIMEOUT   = 2000;

    logic                   clk;
    logic                   prev_rst;
    logic                   backend_flush;
    addr_t                  backend_redirect_pc;
    logic                   instr_valid;
    logic                   instr_ready;
    inst_t [IF_WIDTH-1:0]   instr_data;
    addr_t                  instr_pc;
    logic                   mem_read;
    addr_t                  mem_addr;
    line_t                  mem_rdata;
    logic                   mem_resp;
    int                     read_count;

    integer                 seed;
    int                     check_errors   = 0;
    int                     timeout_errors = 0;
    int                     blocks_taken   = 0;
    addr_t                  exp_pc         = RESET_PC;
    logic                   rst_d          = 1'b0;
    logic                   held           = 1'b0;    // Block offered but not taken.
    addr_t                  held_pc;
    inst_t [IF_WIDTH-1:0]   held_data;
    logic                   mem_read_d     = 1'b0;
    logic                   mem_resp_d     = 1'b0;
    addr_t                  mem_addr_d;
    logic                   hit_window;
    int                     hit_reads;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fetch_top #(
        .IF_WIDTH               (IF_WIDTH),
        .ICACHE_SETS            (ICACHE_SETS),
        .QUEUE_DEPTH            (QUEUE_DEPTH)
    ) i_fetch_top (
        .clk                    (clk),
        .prev_rst               (prev_rst),
        .backend_flush          (backend_flush),
        .backend_redirect_pc    (backend_redirect_pc),
        .instr_valid            (instr_valid),
        .instr_ready            (instr_ready),
        .instr_data             (instr_data),
        .instr_pc               (instr_pc),
        .mem_read               (mem_read),
        .mem_addr               (mem_addr),
        .mem_rdata              (mem_rdata),
        .mem_resp               (mem_resp)
    );

    tb_cacheline_mem i_mem (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp),
        .read_count (read_count)
    );

    function automatic inst_t expected_word(input addr_t pc, input int i);
        addr_t blk;
        blk = pc & ~addr_t'(BLK_BYTES - 1);
        return (blk + addr_t'(4 * i)) ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            check_errors++;
            $display("CHECK FAILED: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // Scoreboard and protocol checks.
    always @(posedge clk) begin
        rst_d <= prev_rst;
        if (rst_d) begin
            check_value("instr_valid", {31'b0, instr_valid}, 32'h0);
            check_value("mem_read", {31'b0, mem_read}, 32'h0);
        end

        mem_read_d <= mem_read;
        mem_resp_d <= mem_resp;
        mem_addr_d <= mem_addr;
        if (mem_read) begin
            check_value("mem_addr low bits", mem_addr & addr_t'(LINE_BYTES - 1), 32'h0);
        end
        if (mem_read_d && !mem_resp_d) begin
            check_value("mem_read", {31'b0, mem_read}, 32'h1);  // Held until mem_resp.
            check_value("mem_addr", mem_addr, mem_addr_d);
        end

        if (prev_rst) begin
            exp_pc <= RESET_PC;
            held   <= 1'b0;
        end else if (backend_flush) begin
            exp_pc <= backend_redirect_pc;              // Anything older is dropped.
            held   <= 1'b0;
        end else begin
            if (held) begin
                check_value("instr_valid", {31'b0, instr_valid}, 32'h1);
                check_value("instr_pc", instr_pc, held_pc);
                for (int i = 0; i < IF_WIDTH; i++) begin
                    check_value($sformatf("instr_data[%0d]", i), instr_data[i], held_data[i]);
                end
            end
            if (instr_valid && instr_ready) begin
                check_value("instr_pc", instr_pc, exp_pc);
                for (int i = 0; i < IF_WIDTH; i++) begin
                    check_value($sformatf("instr_data[%0d]", i), instr_data[i],
                                expected_word(exp_pc, i));
                end
                if (hit_window) begin
                    check_value("read_count", read_count, hit_reads);
                end
                exp_pc       <= (exp_pc + addr_t'(BLK_BYTES)) & ~addr_t'(BLK_BYTES - 1);
                blocks_taken <= blocks_taken + 1;
            end
            held      <= instr_valid && !instr_ready;
            held_pc   <= instr_pc;
            held_data <= instr_data;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic consume_blocks(input int n);
        int target;
        int cycles;
        target = blocks_taken + n;
        cycles = 0;
        instr_ready <= 1'b1;
        while (blocks_taken < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (blocks_taken < target) begin
            timeout_errors++;
            $display("Timed out waiting for %0d blocks from the fetch unit", n);
        end
    endtask

    task automatic wait_mem_read_level(input logic level);
        int cycles;
        cycles = 0;
        while (mem_read !== level && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (mem_read !== level) begin
            timeout_errors++;
            $display("Timed out waiting for mem_read to become %0b", level);
        end
    endtask

    task automatic redirect(input addr_t target);
        @(posedge clk);
        backend_flush       <= 1'b1;
        backend_redirect_pc <= target;
        @(posedge clk);
        backend_flush       <= 1'b0;
    endtask

    initial begin
        seed                = 32'hff0f_16d1;
        prev_rst            = 1'b1;
        backend_flush       = 1'b0;
        backend_redirect_pc = '0;
        instr_ready         = 1'b0;
        hit_window          = 1'b0;
        hit_reads           = 0;
        repeat (16) @(posedge clk);
        prev_rst <= 1'b0;

        consume_blocks(16);                             // Sequential stream from reset.
        instr_ready <= 1'b0;
        wait_cycles(20 + int'($unsigned($random(seed)) % 40));
        consume_blocks(12);

        instr_ready <= 1'b0;                            // Queue fills, fetch goes quiet.
        wait_cycles(64);
        wait_mem_read_level(1'b0);
        redirect(RESET_PC + 32'h4);                     // Line still cached.
        wait_cycles(2);
        hit_reads  <= read_count;
        hit_window <= 1'b1;
        consume_blocks(4);
        hit_window <= 1'b0;

        redirect(32'h0000_4a2c);                        // Cold line.
        wait_mem_read_level(1'b1);
        redirect(32'h2000_0104);                        // While that miss is in flight.
        consume_blocks(8);
        instr_ready <= 1'b0;
        wait_cycles(4);

        $display("Errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
cpu_params.sv
icache.sv
if1_stage.sv
frontend_top.sv
instr_queue.sv
fetch_top.sv
tb_cacheline_mem.sv
tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
